//--- verilog/mp_pkg.sv
package mp_pkg;

    // Vector length, also the square matrix dimension
    localparam int VEC_LEN = 4;

    localparam int ORIG_W = 16;
    localparam int LOW_W  = 8;

    // Quantization drops the low byte of a full-precision value
    localparam int QUANT_SHIFT = ORIG_W - LOW_W;

    localparam int ACC_W = 40;

    // An element is an outlier when its magnitude is strictly above this
    localparam int OUTLIER_THRESHOLD = 6;
    localparam int HIGH_SLOTS        = 2;

    typedef logic signed [ORIG_W-1:0] orig_t;
    typedef logic signed [LOW_W-1:0]  low_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    typedef orig_t [VEC_LEN-1:0] orig_vec_t;
    typedef low_t  [VEC_LEN-1:0] low_vec_t;
    typedef acc_t  [VEC_LEN-1:0] acc_vec_t;

    // Row-major, so mat[row][col]
    typedef orig_t [VEC_LEN-1:0][VEC_LEN-1:0] weight_mat_t;
    typedef low_t  [VEC_LEN-1:0][VEC_LEN-1:0] qweight_mat_t;

    // Each position is live in exactly one of the two fields
    typedef struct packed {
        orig_vec_t high;
        low_vec_t  low;
    } split_vec_t;

    typedef enum logic {
        NO_WEIGHTS,
        LOADED
    } ctrl_state_t;

endpackage

//--- verilog/outlier_scatter.sv
`timescale 1ns/100ps

module outlier_scatter
    import mp_pkg::*;
(
    input  orig_vec_t  data_in,
    output split_vec_t split
);

    logic [VEC_LEN-1:0] is_outlier;

    // Magnitude test done as two signed compares, which also covers the
    // most negative value without an overflowing absolute value
    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            is_outlier[i] = (data_in[i] > OUTLIER_THRESHOLD) ||
                            (data_in[i] < -OUTLIER_THRESHOLD);
        end
    end

    // Scan in index order so the lowest-indexed outliers win the slots
    always_comb begin
        int taken;

        taken = 0;
        split = '0;
        for (int i = 0; i < VEC_LEN; i++) begin
            if (is_outlier[i] && (taken < HIGH_SLOTS)) begin
                split.high[i] = data_in[i];
                taken         = taken + 1;
            end else begin
                // Surplus outliers fall through to the quantized path
                split.low[i] = low_t'(data_in[i] >>> QUANT_SHIFT);
            end
        end
    end

endmodule

//--- verilog/weight_bank.sv
`timescale 1ns/100ps

module weight_bank
    import mp_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         load_en,
    input  weight_mat_t  weight,
    output weight_mat_t  full_w,
    output qweight_mat_t quant_w
);

    qweight_mat_t quant_next;

    // Quantized copy keeps the high byte of each weight
    always_comb begin
        for (int r = 0; r < VEC_LEN; r++) begin
            for (int c = 0; c < VEC_LEN; c++) begin
                quant_next[r][c] = low_t'(weight[r][c] >>> QUANT_SHIFT);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full_w  <= '0;
            quant_w <= '0;
        end else if (load_en) begin
            full_w  <= weight;
            quant_w <= quant_next;
        end
    end

endmodule

//--- verilog/fixed_matvec.sv
`timescale 1ns/100ps

module fixed_matvec
    import mp_pkg::*;
#(
    parameter int OP_W = ORIG_W
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        en,
    input  logic signed [VEC_LEN-1:0][OP_W-1:0]         vec,
    input  logic signed [VEC_LEN-1:0][VEC_LEN-1:0][OP_W-1:0] mat,
    output acc_vec_t                                    result
);

    acc_vec_t row_sum;

    // Operands are widened to ACC_W before the multiply so that the
    // product and the running sum are both kept at full width
    always_comb begin
        logic signed [OP_W-1:0] m_el;
        logic signed [OP_W-1:0] v_el;

        for (int r = 0; r < VEC_LEN; r++) begin
            row_sum[r] = '0;
            for (int c = 0; c < VEC_LEN; c++) begin
                m_el       = mat[r][c];
                v_el       = vec[c];
                row_sum[r] = row_sum[r] + acc_t'(m_el) * acc_t'(v_el);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (en) begin
            result <= row_sum;
        end
    end

endmodule

//--- verilog/mix_gather.sv
`timescale 1ns/100ps

module mix_gather
    import mp_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     en,
    input  acc_vec_t high_sum,
    input  acc_vec_t low_sum,
    output acc_vec_t data_out
);

    acc_vec_t mixed;

    // Both low operands lost QUANT_SHIFT bits, so the product is brought
    // back up by twice that before it joins the exact high-path sum
    always_comb begin
        for (int i = 0; i < VEC_LEN; i++) begin
            mixed[i] = high_sum[i] + (low_sum[i] <<< (2 * QUANT_SHIFT));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (en) begin
            data_out <= mixed;
        end
    end

endmodule

//--- verilog/stream_ctrl.sv
`timescale 1ns/100ps

module stream_ctrl
    import mp_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic data_in_valid,
    input  logic weight_valid,
    input  logic data_out_ready,
    output logic data_in_ready,
    output logic weight_ready,
    output logic data_out_valid,
    output logic load_en,
    output logic s1_en,
    output logic s2_en
);

    ctrl_state_t state;
    logic        s1_valid;
    logic        s2_valid;
    logic        s1_adv;
    logic        s2_adv;
    logic        in_fire;

    // Stage 2 moves when it is empty or its beat is taken downstream
    assign s2_adv = !s2_valid || data_out_ready;
    assign s1_adv = !s1_valid || s2_adv;

    // A pending weight load blocks new data so the pipe can drain
    assign data_in_ready = (state == LOADED) && s1_adv && !weight_valid;
    assign weight_ready  = !s1_valid && !s2_valid;

    assign in_fire = data_in_valid && data_in_ready;
    assign load_en = weight_valid && weight_ready;

    assign s1_en          = in_fire;
    assign s2_en          = s2_adv && s1_valid;
    assign data_out_valid = s2_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= NO_WEIGHTS;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (load_en) begin
                state <= LOADED;
            end
            if (s1_adv) begin
                s1_valid <= in_fire;
            end
            if (s2_adv) begin
                s2_valid <= s1_valid;
            end
        end
    end

endmodule

//--- verilog/llm_int8_linear.sv
`timescale 1ns/100ps

module llm_int8_linear
    import mp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  orig_vec_t   data_in,
    input  logic        data_in_valid,
    output logic        data_in_ready,
    input  weight_mat_t weight,
    input  logic        weight_valid,
    output logic        weight_ready,
    output acc_vec_t    data_out,
    output logic        data_out_valid,
    input  logic        data_out_ready
);

    split_vec_t   split;
    weight_mat_t  full_w;
    qweight_mat_t quant_w;
    acc_vec_t     high_sum;
    acc_vec_t     low_sum;
    logic         load_en;
    logic         s1_en;
    logic         s2_en;

    outlier_scatter u_scatter (
        .data_in (data_in),
        .split   (split)
    );

    weight_bank u_weight_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .load_en (load_en),
        .weight  (weight),
        .full_w  (full_w),
        .quant_w (quant_w)
    );

    // Exact path for the outlier elements
    fixed_matvec #(
        .OP_W (ORIG_W)
    ) high_matvec (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (s1_en),
        .vec    (split.high),
        .mat    (full_w),
        .result (high_sum)
    );

    // Int8 path for everything else
    fixed_matvec #(
        .OP_W (LOW_W)
    ) low_matvec (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (s1_en),
        .vec    (split.low),
        .mat    (quant_w),
        .result (low_sum)
    );

    mix_gather u_gather (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (s2_en),
        .high_sum (high_sum),
        .low_sum  (low_sum),
        .data_out (data_out)
    );

    stream_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in_valid  (data_in_valid),
        .weight_valid   (weight_valid),
        .data_out_ready (data_out_ready),
        .data_in_ready  (data_in_ready),
        .weight_ready   (weight_ready),
        .data_out_valid (data_out_valid),
        .load_en        (load_en),
        .s1_en          (s1_en),
        .s2_en          (s2_en)
    );

endmodule

//--- dv/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
    output logic clk,
    output logic rst_n
);

    localparam realtime HALF_PERIOD  = 10.0;
    localparam int      RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release lands just after an edge, like the other testbench inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

//--- dv/llm_int8_linear_sva.sv
`timescale 1ns/100ps

module llm_int8_linear_sva
    import mp_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input orig_vec_t   data_in,
    input logic        data_in_valid,
    input logic        data_in_ready,
    input weight_mat_t weight,
    input logic        weight_valid,
    input logic        weight_ready,
    input acc_vec_t    data_out,
    input logic        data_out_valid,
    input logic        data_out_ready
);

    // A stalled source keeps its payload until the transfer
    data_in_stable: assert property (@(posedge clk) disable iff (!rst_n)
        data_in_valid && !data_in_ready |=> $stable(data_in))
        else $error("data_in changed while stalled");

    weight_stable: assert property (@(posedge clk) disable iff (!rst_n)
        weight_valid && !weight_ready |=> $stable(weight))
        else $error("weight changed while stalled");

    data_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out))
        else $error("data_out dropped or changed under back-pressure");

    out_valid_after_reset: assert property (@(posedge clk)
        !rst_n |=> !data_out_valid)
        else $error("data_out_valid high right after reset");

    // Weights may only change with the pipeline empty
    no_load_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        data_out_valid |-> !weight_ready)
        else $error("weight_ready high while an output is pending");

endmodule

//--- dv/tb_llm_int8_linear.sv
`timescale 1ns/100ps

module tb_llm_int8_linear
    import mp_pkg::*;
;

    localparam int SEED       = 76468;
    localparam int NUM_ROWS   = 16;
    localparam int MAX_CYCLES = 40 * NUM_ROWS + 100;

    logic        clk;
    logic        rst_n;
    orig_vec_t   data_in;
    logic        data_in_valid;
    logic        data_in_ready;
    weight_mat_t weight;
    logic        weight_valid;
    logic        weight_ready;
    acc_vec_t    data_out;
    logic        data_out_valid;
    logic        data_out_ready = 1'b0;

    // Stimulus table, one entry per vector
    int          row_wset  [NUM_ROWS];
    orig_vec_t   row_vec   [NUM_ROWS];
    int          row_stall [NUM_ROWS];

    acc_vec_t    exp_q[$];
    int          in_cyc_q[$];
    weight_mat_t cur_w;
    int          cycle      = 0;
    int          accept_cyc = 0;
    int          out_count  = 0;
    int          waited     = 0;
    int          mismatches = 0;
    int          ctrl_errs  = 0;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    llm_int8_linear dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .weight         (weight),
        .weight_valid   (weight_valid),
        .weight_ready   (weight_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    bind llm_int8_linear llm_int8_linear_sva sva_checks (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_in        (data_in),
        .data_in_valid  (data_in_valid),
        .data_in_ready  (data_in_ready),
        .weight         (weight),
        .weight_valid   (weight_valid),
        .weight_ready   (weight_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

    function automatic weight_mat_t build_weights(input int set);
        weight_mat_t w;

        for (int r = 0; r < VEC_LEN; r++) begin
            for (int c = 0; c < VEC_LEN; c++) begin
                if (set == 0) begin
                    w[r][c] = orig_t'((r * VEC_LEN + c - 6) * 300 + 17);
                end else begin
                    w[r][c] = orig_t'(((r + 2 * c) % 5 - 2) * 4096 - 129 * c + r);
                end
            end
        end
        return w;
    endfunction

    function automatic orig_vec_t make_vec(input int a0, input int a1, input int a2,
                                           input int a3);
        orig_vec_t v;

        v[0] = orig_t'(a0);
        v[1] = orig_t'(a1);
        v[2] = orig_t'(a2);
        v[3] = orig_t'(a3);
        return v;
    endfunction

    // Reference model that takes exact products for the first outliers and
    // 8-bit products scaled back up by two quantization shifts for the rest
    function automatic acc_vec_t expected_output(input orig_vec_t v, input weight_mat_t w);
        acc_vec_t res;
        bit       high [VEC_LEN];
        int       used;
        int       mag;
        longint   exact;
        longint   coarse;

        used = 0;
        for (int i = 0; i < VEC_LEN; i++) begin
            mag     = (v[i] < 0) ? -int'(v[i]) : int'(v[i]);
            high[i] = (mag > OUTLIER_THRESHOLD) && (used < HIGH_SLOTS);
            if (high[i]) used++;
        end
        for (int r = 0; r < VEC_LEN; r++) begin
            exact  = 0;
            coarse = 0;
            for (int c = 0; c < VEC_LEN; c++) begin
                if (high[c]) begin
                    exact += longint'(w[r][c]) * longint'(v[c]);
                end else begin
                    coarse += (longint'(w[r][c]) >>> QUANT_SHIFT) *
                              (longint'(v[c]) >>> QUANT_SHIFT);
                end
            end
            res[r] = acc_t'(exact + coarse * (longint'(1) << (2 * QUANT_SHIFT)));
        end
        return res;
    endfunction

    // Output latency is fixed only when neither this beat nor the one ahead was held
    function automatic bit fixed_latency(input int idx);
        return (row_stall[idx] == 0) && (idx == 0 || row_stall[idx-1] == 0);
    endfunction

    // A row follows its predecessor on the next edge unless a reload sits
    // between them or the output two rows back was held
    function automatic bit back_to_back(input int idx);
        return (idx > 0) && (row_wset[idx] == row_wset[idx-1]) &&
               (idx < 2 || row_stall[idx-2] == 0);
    endfunction

    task automatic set_row(input int idx, input int set, input orig_vec_t v, input int stall);
        row_wset[idx]  = set;
        row_vec[idx]   = v;
        row_stall[idx] = stall;
    endtask

    task automatic fill_table();
        set_row(0, 0, make_vec(3, -2, 6, -6), 0);
        set_row(1, 0, make_vec(0, 1, 2, 5), 0);
        set_row(2, 0, make_vec(1000, 2, -3, 4), 0);
        set_row(3, 0, make_vec(5, -2000, 3, -300), 0);
        set_row(4, 0, make_vec(300, -5000, 700, 32767), 2);
        set_row(5, 0, make_vec(-32768, -7, 9, 100), 0);
        for (int r = 6; r < 12; r++) begin
            set_row(r, 0, make_vec($urandom, $urandom, $urandom, $urandom),
                    $urandom_range(0, 3));
        end
        // Second weight set forces a reload after the pipeline drains
        set_row(12, 1, make_vec(4, -1, 0, 6), 0);
        set_row(13, 1, make_vec(-1500, 2, 800, -3), 0);
        set_row(14, 1, make_vec(7, -7, 8, -8), 0);
        set_row(15, 1, make_vec(12345, -4, -4, 200), 0);
    endtask

    task automatic load_weights(input int set);
        weight       = build_weights(set);
        weight_valid = 1'b1;
        do @(posedge clk); while (!weight_ready);
        cur_w = weight;
        #2;
        weight_valid = 1'b0;
    endtask

    task automatic send_vector(input orig_vec_t v);
        data_in       = v;
        data_in_valid = 1'b1;
        do @(posedge clk); while (!data_in_ready);
        accept_cyc = cycle;
        exp_q.push_back(expected_output(v, cur_w));
        in_cyc_q.push_back(cycle);
        #2;
        data_in_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d outputs received",
                     cycle, out_count, NUM_ROWS);
            $display("tests failed");
            $finish;
        end
    end

    // Each output beat is held off for its table stall length and then checked
    always @(posedge clk) begin : monitor
        acc_vec_t want;
        int       in_cyc;

        if (rst_n && data_out_valid && data_out_ready) begin
            assert (exp_q.size() > 0) else begin
                mismatches++;
                $display("Output beat at %0t arrived with no vector outstanding", $time);
            end
            if (exp_q.size() > 0) begin
                want   = exp_q.pop_front();
                in_cyc = in_cyc_q.pop_front();
                assert (data_out == want) else begin
                    mismatches++;
                    $display("Fail at %0t: output %0d is %h, expected %h",
                             $time, out_count, data_out, want);
                end
                // Two edges of latency whenever nothing ahead was stalled
                if (fixed_latency(out_count)) begin
                    assert (cycle - in_cyc == 2) else begin
                        mismatches++;
                        $display("Fail at %0t: output %0d took %0d edges, expected 2",
                                 $time, out_count, cycle - in_cyc);
                    end
                end
            end
            out_count++;
            waited = 0;
        end else if (rst_n && data_out_valid) begin
            waited++;
        end
        #2;
        data_out_ready = (out_count >= NUM_ROWS) || (waited >= row_stall[out_count]);
    end

    initial begin
        int prev_accept;

        void'($urandom(SEED));
        data_in       = '0;
        data_in_valid = 1'b0;
        weight        = '0;
        weight_valid  = 1'b0;
        cur_w         = '0;
        prev_accept   = 0;
        fill_table();
        wait (rst_n);
        @(posedge clk);
        #2;
        // Data offered before any weight load must not be taken
        data_in       = row_vec[0];
        data_in_valid = 1'b1;
        repeat (6) begin
            @(posedge clk);
            assert (!data_in_ready) else begin
                ctrl_errs++;
                $display("data_in_ready went high before any weights were loaded, at %0t",
                         $time);
            end
        end
        #2;
        data_in_valid = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (r == 0 || row_wset[r] != row_wset[r-1]) begin
                load_weights(row_wset[r]);
            end
            prev_accept = accept_cyc;
            send_vector(row_vec[r]);
            if (back_to_back(r)) begin
                assert (accept_cyc == prev_accept + 1) else begin
                    ctrl_errs++;
                    $display("Fail at %0t: row %0d accepted %0d edges after the previous row",
                             $time, r, accept_cyc - prev_accept);
                end
            end
        end
        wait (out_count >= NUM_ROWS);
        repeat (4) @(posedge clk);
        $display("Errors: %0d output mismatches, %0d control errors, %0d of %0d outputs seen",
                 mismatches, ctrl_errs, out_count, NUM_ROWS);
        if (mismatches == 0 && ctrl_errs == 0 && out_count == NUM_ROWS) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- list.f
verilog/mp_pkg.sv
verilog/outlier_scatter.sv
verilog/weight_bank.sv
verilog/fixed_matvec.sv
verilog/mix_gather.sv
verilog/stream_ctrl.sv
verilog/llm_int8_linear.sv
dv/clk_gen.sv
dv/llm_int8_linear_sva.sv
dv/tb_llm_int8_linear.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_llm_int8_linear
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard verilog/*.sv dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, a missing pass line counts as a failure
run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
